// ==== snd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Sound board shared definitions
// Memory map, I/O register offsets, sample pacing and the bus,
// register and PCM command types used across the board
//////////////////////////////////////////////////////////////////////

package snd_pkg;

    localparam int addr_w = 16;
    localparam int rom_aw = 18;
    localparam int pcm_aw = 16;

    localparam logic [addr_w-1:0] ram_base = 16'hD000;   // 2 KB work RAM
    localparam int                ram_aw   = 11;
    localparam logic [addr_w-1:0] io_base  = 16'hF000;   // 16 byte I/O page

    localparam logic [3:0] reg_tone_period = 4'd0;
    localparam logic [3:0] reg_tone_ctrl   = 4'd1;   // [3:0] volume, 4 pan_l, 5 pan_r
    localparam logic [3:0] reg_pcm_cmd     = 4'd2;
    localparam logic [3:0] reg_bank        = 4'd3;
    localparam logic [3:0] reg_latch0      = 4'd4;
    localparam logic [3:0] reg_latch1      = 4'd5;
    localparam logic [3:0] reg_status      = 4'd6;

    localparam int sample_div = 64;   // Clocks per audio sample

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [addr_w-1:0] adr;
        logic [7:0]        dat_w;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic [7:0] period;
        logic [3:0] volume;
        logic       pan_l;
        logic       pan_r;
        logic       period_wr;   // Restarts the phase
    } tone_regs_t;

    // Command byte seen either as a phrase start or as a volume word
    typedef union packed {
        struct packed {
            logic       marker;   // Set for a start word
            logic [6:0] phrase;
        } start;
        struct packed {
            logic       marker;   // Clear for a volume word
            logic [2:0] unused;
            logic [3:0] volume;
        } vol;
    } pcm_cmd_t;

    typedef struct packed {
        logic     wr;
        pcm_cmd_t cmd;
    } pcm_wr_t;

endpackage

// ==== snd_bus_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Sound board bus decode
// Wishbone classic slave standing in for the sound CPU memory bus.
// Decodes program ROM, banked window, work RAM and the I/O page,
// holds the bank, tone and PCM registers and muxes the read data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module snd_bus_decode
    import snd_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    input  logic [7:0]        snd_latch0,
    input  logic [7:0]        snd_latch1,
    output logic [rom_aw-1:0] rom_addr,
    output logic              rom_cs,
    input  logic [7:0]        rom_data,
    input  logic              rom_ok,
    output tone_regs_t        tone_regs,
    output pcm_wr_t           pcm_wr,
    input  logic              pcm_busy
);

    logic [7:0]        ram [0:2**ram_aw-1];
    logic [7:0]        ram_q;
    logic [ram_aw-1:0] ram_idx;
    logic              ram_we;
    logic              req, in_rom, in_ram, in_io;
    logic              busy;   // Decode registered, access in progress
    logic              ack;
    logic              rom_sel, ram_sel, io_sel, we_q;
    logic [3:0]        io_off;
    logic              wr_io;
    logic [7:0]        rd_mux;
    logic [7:0]        dat_r;
    logic [2:0]        bank;
    logic              pcm_wr_q;
    pcm_cmd_t          pcm_cmd_q;

    assign req    = wb_req.cyc && wb_req.stb;
    assign in_rom = !wb_req.adr[15] || wb_req.adr[15:14] == 2'b10;
    assign in_ram = wb_req.adr[addr_w-1:ram_aw] == ram_base[addr_w-1:ram_aw];
    assign in_io  = wb_req.adr[addr_w-1:4] == io_base[addr_w-1:4];

    // Program ROM is selected straight from the bus
    assign rom_cs   = req && !wb_req.we && in_rom;
    assign rom_addr = wb_req.adr[15] ? {1'b1, bank, wb_req.adr[13:0]}
                                     : {3'b000, wb_req.adr[14:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            ack     <= 1'b0;
            rom_sel <= 1'b0;
            ram_sel <= 1'b0;
            io_sel  <= 1'b0;
            we_q    <= 1'b0;
            io_off  <= 4'd0;
        end else begin
            ack <= 1'b0;
            if (!busy && !ack && req) begin   // stb still high during ack
                busy    <= 1'b1;
                rom_sel <= rom_cs;
                ram_sel <= in_ram;
                io_sel  <= in_io;
                we_q    <= wb_req.we;
                io_off  <= wb_req.adr[3:0];
            end else if (busy && (!rom_sel || rom_ok)) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
        end
    end

    assign ram_idx = wb_req.adr[ram_aw-1:0];
    assign ram_we  = busy && ram_sel && we_q;
    assign wr_io   = busy && io_sel && we_q;

    always_ff @(posedge clk) begin
        if (ram_we) ram[ram_idx] <= wb_req.dat_w;
        ram_q <= ram[ram_idx];
    end

    always_comb begin
        rd_mux = 8'hFF;   // Unmapped, ROM writes and write-only registers
        if (rom_sel) begin
            rd_mux = rom_data;
        end else if (ram_sel && !we_q) begin
            rd_mux = ram_q;
        end else if (io_sel && !we_q) begin
            case (io_off)
                reg_latch0: rd_mux = snd_latch0;
                reg_latch1: rd_mux = snd_latch1;
                reg_status: rd_mux = {7'd0, pcm_busy};
                default:    rd_mux = 8'hFF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busy) dat_r <= rd_mux;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank      <= 3'd0;
            tone_regs <= '0;
            pcm_wr_q  <= 1'b0;
        end else begin
            tone_regs.period_wr <= 1'b0;
            pcm_wr_q            <= 1'b0;
            if (wr_io) begin
                case (io_off)
                    reg_tone_period: begin
                        tone_regs.period    <= wb_req.dat_w;
                        tone_regs.period_wr <= 1'b1;
                    end
                    reg_tone_ctrl: begin
                        tone_regs.volume <= wb_req.dat_w[3:0];
                        tone_regs.pan_l  <= wb_req.dat_w[4];
                        tone_regs.pan_r  <= wb_req.dat_w[5];
                    end
                    reg_pcm_cmd: pcm_wr_q <= 1'b1;
                    reg_bank:    bank     <= wb_req.dat_w[2:0];
                    default:     ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_io && io_off == reg_pcm_cmd) pcm_cmd_q <= wb_req.dat_w;
    end

    assign pcm_wr.wr     = pcm_wr_q;
    assign pcm_wr.cmd    = pcm_cmd_q;
    assign wb_rsp.ack    = ack;
    assign wb_rsp.dat_r  = dat_r;

    // Master must still be in its cycle when we answer
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |-> wb_req.cyc && wb_req.stb);

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

endmodule

// ==== snd_tone.sv ====
//////////////////////////////////////////////////////////////////////
// Square-wave tone voice
// Counts sample strobes against the period and toggles the phase,
// giving plus or minus volume times 256 with its pan bits
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module snd_tone
    import snd_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_cen,
    input  tone_regs_t         tone_regs,
    output logic signed [15:0] tone_out,
    output logic               tone_l,
    output logic               tone_r
);

    logic [7:0]         cnt, cnt_nxt;
    logic               phase, phase_nxt;
    logic signed [15:0] amp;

    always_comb begin
        cnt_nxt   = cnt + 8'd1;
        phase_nxt = phase;
        if (tone_regs.period == 8'd0) begin   // Held high
            cnt_nxt   = 8'd0;
            phase_nxt = 1'b1;
        end else if (cnt_nxt == tone_regs.period) begin
            cnt_nxt   = 8'd0;
            phase_nxt = !phase;
        end
    end

    assign amp = {4'd0, tone_regs.volume, 8'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= 8'd0;
            phase    <= 1'b1;
            tone_out <= 16'sd0;
            tone_l   <= 1'b0;
            tone_r   <= 1'b0;
        end else begin
            if (sample_cen) begin
                cnt      <= cnt_nxt;
                phase    <= phase_nxt;
                tone_out <= phase_nxt ? amp : -amp;
                tone_l   <= tone_regs.pan_l;   // Pan follows the sample
                tone_r   <= tone_regs.pan_r;
            end
            if (tone_regs.period_wr) begin
                cnt   <= 8'd0;
                phase <= 1'b1;
            end
        end
    end

endmodule

// ==== snd_pcm.sv ====
//////////////////////////////////////////////////////////////////////
// PCM phrase player
// Start word arms a phrase, the following volume word starts it.
// Signed bytes come from sample ROM one per strobe, scaled by
// volume, until the 0x80 end marker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module snd_pcm
    import snd_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_cen,
    input  pcm_wr_t            pcm_wr,
    output logic [pcm_aw-1:0]  pcm_addr,
    output logic               pcm_cs,
    input  logic [7:0]         pcm_data,
    input  logic               pcm_ok,
    output logic signed [15:0] pcm_out,
    output logic               pcm_busy
);

    logic [pcm_aw-1:0]  ptr;         // Next byte to fetch
    logic [3:0]         vol;
    logic [7:0]         data_q;      // Prefetched byte
    logic               armed, playing, valid;
    logic               fetch_pend;
    logic               stale;       // Fetch in flight from an old phrase
    logic signed [15:0] scaled;

    assign scaled   = $signed(data_q) * $signed({1'b0, vol}) * 16'sd4;
    assign pcm_busy = armed || playing;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr        <= '0;
            vol        <= 4'd0;
            data_q     <= 8'd0;
            armed      <= 1'b0;
            playing    <= 1'b0;
            valid      <= 1'b0;
            fetch_pend <= 1'b0;
            stale      <= 1'b0;
            pcm_cs     <= 1'b0;
            pcm_addr   <= '0;
            pcm_out    <= 16'sd0;
        end else begin
            // Sample ROM fetch
            if (pcm_cs && pcm_ok) begin
                pcm_cs <= 1'b0;
                stale  <= 1'b0;
                if (!stale) begin
                    data_q <= pcm_data;
                    valid  <= 1'b1;
                end
            end else if (!pcm_cs && fetch_pend) begin
                pcm_cs     <= 1'b1;
                pcm_addr   <= ptr;
                ptr        <= ptr + 1'b1;
                fetch_pend <= 1'b0;
            end

            // Late fetch simply holds the last output
            if (sample_cen && playing && valid) begin
                valid <= 1'b0;
                if (data_q == 8'h80) begin
                    playing <= 1'b0;
                    pcm_out <= 16'sd0;
                end else begin
                    pcm_out    <= scaled;
                    fetch_pend <= 1'b1;
                end
            end

            if (pcm_wr.wr) begin
                if (pcm_wr.cmd.start.marker) begin
                    ptr        <= {1'b0, pcm_wr.cmd.start.phrase, 8'h00};
                    armed      <= 1'b1;
                    playing    <= 1'b0;
                    valid      <= 1'b0;
                    fetch_pend <= 1'b0;
                    stale      <= pcm_cs && !pcm_ok;
                    pcm_out    <= 16'sd0;
                end else if (armed) begin   // Volume word after a start
                    vol        <= pcm_wr.cmd.vol.volume;
                    armed      <= 1'b0;
                    playing    <= 1'b1;
                    fetch_pend <= 1'b1;
                end
            end
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        pcm_cs && !pcm_ok |=> $stable(pcm_addr));

endmodule

// ==== snd_mixer.sv ====
//////////////////////////////////////////////////////////////////////
// Sound mixer
// Paces the sample rate and sums tone and PCM per channel
// with source enables and tone panning
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module snd_mixer
    import snd_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               enable_tone,
    input  logic               enable_pcm,
    input  logic signed [15:0] tone_out,
    input  logic               tone_l,
    input  logic               tone_r,
    input  logic signed [15:0] pcm_out,
    output logic               sample_cen,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    logic [$clog2(sample_div)-1:0] div_cnt;
    logic                          cen_d;   // Voices have updated
    logic signed [15:0]            pcm_term;

    assign sample_cen = div_cnt == sample_div - 1;
    assign pcm_term   = enable_pcm ? pcm_out : 16'sd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            cen_d   <= 1'b0;
            sample  <= 1'b0;
            left    <= 16'sd0;
            right   <= 16'sd0;
        end else begin
            div_cnt <= sample_cen ? '0 : div_cnt + 1'b1;
            cen_d   <= sample_cen;
            sample  <= cen_d;
            if (cen_d) begin
                left  <= ((enable_tone && tone_l) ? tone_out : 16'sd0) + pcm_term;
                right <= ((enable_tone && tone_r) ? tone_out : 16'sd0) + pcm_term;
            end
        end
    end

endmodule

// ==== snd_board.sv ====
//////////////////////////////////////////////////////////////////////
// Sound board top level
// Bus decode feeding the tone and PCM voices and the mixer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module snd_board
    import snd_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  wb_req_t            wb_req,
    output wb_rsp_t            wb_rsp,
    input  logic [7:0]         snd_latch0,
    input  logic [7:0]         snd_latch1,
    input  logic               enable_tone,
    input  logic               enable_pcm,
    output logic [rom_aw-1:0]  rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic [pcm_aw-1:0]  pcm_addr,
    output logic               pcm_cs,
    input  logic [7:0]         pcm_data,
    input  logic               pcm_ok,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    tone_regs_t         tone_regs;
    pcm_wr_t            pcm_wr;
    logic               pcm_busy;
    logic               sample_cen;
    logic signed [15:0] tone_out, pcm_out;
    logic               tone_l, tone_r;

    snd_bus_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .snd_latch0 (snd_latch0),
        .snd_latch1 (snd_latch1),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .tone_regs  (tone_regs),
        .pcm_wr     (pcm_wr),
        .pcm_busy   (pcm_busy)
    );

    snd_tone u_tone (
        .clk        (clk),
        .rst        (rst),
        .sample_cen (sample_cen),
        .tone_regs  (tone_regs),
        .tone_out   (tone_out),
        .tone_l     (tone_l),
        .tone_r     (tone_r)
    );

    snd_pcm u_pcm (
        .clk        (clk),
        .rst        (rst),
        .sample_cen (sample_cen),
        .pcm_wr     (pcm_wr),
        .pcm_addr   (pcm_addr),
        .pcm_cs     (pcm_cs),
        .pcm_data   (pcm_data),
        .pcm_ok     (pcm_ok),
        .pcm_out    (pcm_out),
        .pcm_busy   (pcm_busy)
    );

    snd_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .enable_tone (enable_tone),
        .enable_pcm  (enable_pcm),
        .tone_out    (tone_out),
        .tone_l      (tone_l),
        .tone_r      (tone_r),
        .pcm_out     (pcm_out),
        .sample_cen  (sample_cen),
        .left        (left),
        .right       (right),
        .sample      (sample)
    );

endmodule

// ==== tb_snd_board.sv ====
//////////////////////////////////////////////////////////////////////
// Sound board testbench
// Program and sample ROM models, a table of bus operations and a
// tone reference model checking RAM, banking, tone, PCM and mixing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_snd_board
    import snd_pkg::*;
;

    localparam logic [1:0] op_wr   = 2'd0;
    localparam logic [1:0] op_rd   = 2'd1;
    localparam logic [1:0] op_wait = 2'd2;   // dat holds the sample count
    localparam int audio_samples   = 60;     // Samples waited outside the table

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] adr;
        logic [7:0]  dat;
        logic [7:0]  exp;
    } row_t;

    logic               clk, rst;
    wb_req_t            wb_req;
    wb_rsp_t            wb_rsp;
    logic [7:0]         snd_latch0, snd_latch1;
    logic               enable_tone, enable_pcm;
    logic [rom_aw-1:0]  rom_addr;
    logic               rom_cs, rom_ok;
    logic [7:0]         rom_data;
    logic [pcm_aw-1:0]  pcm_addr;
    logic               pcm_cs, pcm_ok;
    logic [7:0]         pcm_data;
    logic signed [15:0] left, right;
    logic               sample;

    row_t               rows[$];
    int                 rom_wait, pcm_wait, cycles, limit, table_samples;
    logic [15:0]        lfsr;
    logic [7:0]         pcm_table [0:8];
    logic [2:0]         cur_bank;
    int                 m_cnt;      // Tone reference model
    logic               m_phase;
    logic [7:0]         m_period;
    logic [3:0]         m_vol;
    logic signed [15:0] m_tone;

    snd_board uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] rom_byte(input logic [rom_aw-1:0] a);
        return a[7:0] ^ a[17:10];
    endfunction

    function automatic logic [rom_aw-1:0] prog_addr(input logic [15:0] a, input logic [2:0] bk);
        if (a[15])
            return {1'b1, bk, a[13:0]};   // Banked window
        return {3'b000, a[14:0]};
    endfunction

    function automatic logic [7:0] pcm_byte(input logic [pcm_aw-1:0] a);
        if (a[15:8] == 8'd1 && a[7:0] <= 8'd8)
            return pcm_table[a[3:0]];
        return 8'h00;
    endfunction

    function automatic logic signed [15:0] tone_term();
        return enable_tone ? m_tone : 16'sd0;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] tmp;
        tmp = 8'd0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
            tmp  = {tmp[6:0], lfsr[0]};
        end
        return tmp;
    endfunction

    // ROM models, waits counted from chip select
    always @(posedge clk) rom_wait <= #2 rom_cs ? rom_wait + 1 : 0;
    always @(posedge clk) pcm_wait <= #2 pcm_cs ? pcm_wait + 1 : 0;
    assign rom_ok   = rom_cs && rom_wait >= 3;
    assign pcm_ok   = pcm_cs && pcm_wait >= 2;

    // Data only valid alongside ok
    assign rom_data = rom_ok ? rom_byte(rom_addr) : 8'hxx;
    assign pcm_data = pcm_ok ? pcm_byte(pcm_addr) : 8'hxx;

    // One tone step per output sample
    always @(posedge clk) begin
        #1;
        if (sample) begin
            if (m_period == 8'd0) begin
                m_cnt   = 0;
                m_phase = 1'b1;
            end else if (m_cnt + 1 == m_period) begin
                m_cnt   = 0;
                m_phase = !m_phase;
            end else begin
                m_cnt = m_cnt + 1;
            end
            m_tone = m_phase ? m_vol * 16'sd256 : -(m_vol * 16'sd256);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("test failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic bus_access(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdata, output logic [rom_aw-1:0] raddr);
        @(posedge clk);
        #2;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        @(posedge clk);
        #1;
        while (!wb_rsp.ack) begin
            @(posedge clk);
            #1;
        end
        rdata = wb_rsp.dat_r;
        raddr = rom_addr;   // Still driven, stb held through ack
        @(posedge clk);
        #2;
        wb_req = '0;
    endtask

    task automatic wait_sample();
        @(posedge clk);
        #4;
        while (!sample) begin
            @(posedge clk);
            #4;
        end
    endtask

    task automatic add_row(input logic [1:0] op, input logic [15:0] adr,
                           input logic [7:0] dat, input logic [7:0] exp);
        rows.push_back('{op, adr, dat, exp});
        if (op == op_wait)
            table_samples += dat;
    endtask

    task automatic build_table();
        logic [7:0]  ram_bytes [4];
        logic [15:0] a;
        logic [2:0]  banks [3];
        banks = '{3'd0, 3'd3, 3'd7};
        for (int i = 0; i < 4; i++) begin
            ram_bytes[i] = rand_byte();
            add_row(op_wr, ram_base + i * 16'h1A5, ram_bytes[i], 8'h00);
        end
        for (int i = 0; i < 4; i++)
            add_row(op_rd, ram_base + i * 16'h1A5, 8'h00, ram_bytes[i]);
        add_row(op_rd, io_base + reg_latch0, 8'h00, snd_latch0);
        add_row(op_rd, io_base + reg_latch1, 8'h00, snd_latch1);
        add_row(op_rd, io_base + reg_status, 8'h00, 8'h00);
        add_row(op_rd, 16'hC000, 8'h00, 8'hFF);   // Unmapped
        add_row(op_rd, 16'hF00A, 8'h00, 8'hFF);
        add_row(op_wr, 16'h1000, 8'h5A, 8'h00);   // ROM write is dropped
        add_row(op_rd, 16'h1000, 8'h00, rom_byte(prog_addr(16'h1000, 3'd0)));
        for (int i = 0; i < 3; i++) begin
            a = 16'h8000 + i * 16'h1357;
            add_row(op_wr, io_base + reg_bank, banks[i], 8'h00);
            add_row(op_rd, a, 8'h00, rom_byte(prog_addr(a, banks[i])));
            add_row(op_rd, 16'hBFFF, 8'h00, rom_byte(prog_addr(16'hBFFF, banks[i])));
            add_row(op_rd, 16'h7FFF, 8'h00, rom_byte(prog_addr(16'h7FFF, banks[i])));
        end
        add_row(op_wait, 16'h0000, 8'd2, 8'h00);
    endtask

    task automatic run_table();
        logic [7:0]        rd;
        logic [rom_aw-1:0] ra;
        foreach (rows[i]) begin
            case (rows[i].op)
                op_wr: begin
                    bus_access(1'b1, rows[i].adr, rows[i].dat, rd, ra);
                    if (rows[i].adr == io_base + reg_bank)
                        cur_bank = rows[i].dat[2:0];
                end
                op_rd: begin
                    bus_access(1'b0, rows[i].adr, 8'h00, rd, ra);
                    check_val("dat_r", rd, rows[i].exp);
                    if (rows[i].adr < 16'hC000)
                        check_val("rom_addr", ra, prog_addr(rows[i].adr, cur_bank));
                end
                default: repeat (rows[i].dat) wait_sample();
            endcase
        end
    endtask

    // Start phrase 1 at volume 2 and check its first bytes
    task automatic play_phrase(input int n_bytes);
        logic [7:0]         rd;
        logic [rom_aw-1:0]  ra;
        logic signed [15:0] pcm_exp;
        wait_sample();
        bus_access(1'b1, io_base + reg_pcm_cmd, 8'h81, rd, ra);
        bus_access(1'b1, io_base + reg_pcm_cmd, 8'h02, rd, ra);
        bus_access(1'b0, io_base + reg_status, 8'h00, rd, ra);
        check_val("status", rd, 8'h01);
        wait_sample();
        while (left == tone_term())
            wait_sample();
        for (int i = 0; i < n_bytes; i++) begin
            if (i > 0)
                wait_sample();
            pcm_exp = $signed(pcm_table[i]) * 16'sd8;
            check_val("left", left, tone_term() + pcm_exp);
            check_val("right", right, pcm_exp);
        end
    endtask

    initial begin
        logic [7:0]        rd;
        logic [rom_aw-1:0] ra;
        rst         = 1'b1;
        wb_req      = '0;
        enable_tone = 1'b0;
        enable_pcm  = 1'b0;
        lfsr        = 16'd17;
        cycles      = 0;
        limit       = 1000000;
        cur_bank    = 3'd0;
        m_cnt       = 0;
        m_phase     = 1'b1;
        m_period    = 8'd0;
        m_vol       = 4'd0;
        m_tone      = 16'sd0;
        pcm_table   = '{8'h10, 8'hF0, 8'h25, 8'hC3, 8'h7F, 8'h81, 8'h08, 8'hE0, 8'h80};
        snd_latch0  = rand_byte();
        snd_latch1  = rand_byte();
        table_samples = 0;
        build_table();
        limit = rows.size() * 20 + (table_samples + audio_samples) * sample_div + 500;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        run_table();

        // Tone on the left only
        @(posedge clk);
        #2 enable_tone = 1'b1;
        wait_sample();
        bus_access(1'b1, io_base + reg_tone_ctrl, 8'h15, rd, ra);
        bus_access(1'b1, io_base + reg_tone_period, 8'd3, rd, ra);
        m_vol    = 4'd5;
        m_period = 8'd3;
        m_cnt    = 0;
        m_phase  = 1'b1;
        repeat (10) begin
            wait_sample();
            check_val("left", left, m_tone);
            check_val("right", right, 16'sd0);
        end

        // PCM alone, through the end marker
        @(posedge clk);
        #2;
        enable_tone = 1'b0;
        enable_pcm  = 1'b1;
        play_phrase(8);
        wait_sample();
        check_val("left", left, 16'sd0);
        check_val("right", right, 16'sd0);
        bus_access(1'b0, io_base + reg_status, 8'h00, rd, ra);
        check_val("status", rd, 8'h00);

        // Both sources, then drop each enable
        @(posedge clk);
        #2 enable_tone = 1'b1;
        play_phrase(4);
        @(posedge clk);
        #2 enable_pcm = 1'b0;
        wait_sample();
        check_val("left", left, m_tone);
        check_val("right", right, 16'sd0);
        @(posedge clk);
        #2 enable_tone = 1'b0;
        wait_sample();
        check_val("left", left, 16'sd0);

        $display("test passed");
        $finish;
    end

endmodule

// ==== files.f ====
snd_pkg.sv
snd_bus_decode.sv
snd_tone.sv
snd_pcm.sv
snd_mixer.sv
snd_board.sv
tb_snd_board.sv

// ==== Bender.yml ====
package:
  name: snd_board

sources:
  - snd_pkg.sv
  - snd_bus_decode.sv
  - snd_tone.sv
  - snd_pcm.sv
  - snd_mixer.sv
  - snd_board.sv
  - target: test
    files:
      - tb_snd_board.sv
